// File: logic/afu_flr_top.sv
`timescale 1ns/1ps

module afu_flr_top (
   input  logic                            clk_csr,
   input  logic                            i_rst,
   input  flr_pkg::t_flr_req               i_flr_req,
   input  flr_pkg::t_flr_req               i_ats_req,
   output logic [flr_pkg::NUM_PORTS-1:0]   o_port_rst,
   output flr_pkg::t_flr_rsp               o_flr_rsp,
   output logic [flr_pkg::NUM_FUNCS-1:0]   o_ats_inval_en
);

   // Decoded FLR, decoder to sequencer
   flr_pkg::t_port_sel port_sel;

   // ----------------------------------------------------------------------
   // FLR routing
   // ----------------------------------------------------------------------
   // Maps PF/VF to management, static region or PR region port
   flr_route_decoder u_route_decoder (
      .clk_csr    (clk_csr),
      .i_rst      (i_rst),
      .i_flr_req  (i_flr_req),
      .o_port_sel (port_sel)
   );

   // ----------------------------------------------------------------------
   // ATS invalidation ownership
   // ----------------------------------------------------------------------
   // Sees every FLR in parallel with the decoder
   // Its enables leave the top untouched
   ats_inval_tracker u_ats_inval_tracker (
      .clk_csr        (clk_csr),
      .i_rst          (i_rst),
      .i_flr_req      (i_flr_req),
      .i_ats_req      (i_ats_req),
      .o_ats_inval_en (o_ats_inval_en)
   );

   // ----------------------------------------------------------------------
   // Port reset and FLR response
   // ----------------------------------------------------------------------
   flr_rsp_sequencer u_rsp_sequencer (
      .clk_csr    (clk_csr),
      .i_rst      (i_rst),
      .i_port_sel (port_sel),
      .o_port_rst (o_port_rst),
      .o_flr_rsp  (o_flr_rsp)
   );

endmodule

// File: logic/ats_inval_tracker.sv
`timescale 1ns/1ps

module ats_inval_tracker (
   input  logic                            clk_csr,
   input  logic                            i_rst,
   input  flr_pkg::t_flr_req               i_flr_req,
   input  flr_pkg::t_flr_req               i_ats_req,
   output logic [flr_pkg::NUM_FUNCS-1:0]   o_ats_inval_en
);

   // ----------------------------------------------------------------------
   // Invalidation ownership
   // ----------------------------------------------------------------------
   // One bit per function, indexed by the flat view of the id
   // Bit set means the FIM still answers ATS invalidations for it
   // Bit clear means the AFU function has taken over
   logic [flr_pkg::NUM_FUNCS-1:0] inval_en;

   always_ff @(posedge clk_csr) begin
      if (i_rst) begin
         // Nothing has asked for a translation yet
         inval_en <= '1;
      end else begin
         // First ATS request hands ownership to the function
         if (i_ats_req.valid) begin
            inval_en[i_ats_req.func.index] <= 1'b0;
         end
         // FLR hands it back
         // Written last so it wins a same-cycle collision
         if (i_flr_req.valid) begin
            inval_en[i_flr_req.func.index] <= 1'b1;
         end
      end
   end

   assign o_ats_inval_en = inval_en;

endmodule

// File: logic/flr_pkg.sv
package flr_pkg;

   // ----------------------------------------------------------------------
   // Function id widths
   // ----------------------------------------------------------------------
   localparam int PF_W      = 2;
   localparam int VF_W      = 3;
   // vf_active flag plus PF and VF numbers
   localparam int FUNC_W    = PF_W + VF_W + 1;
   localparam int NUM_FUNCS = 2 ** FUNC_W;

   // ----------------------------------------------------------------------
   // AFU ports
   // ----------------------------------------------------------------------
   localparam int NUM_PORTS = 3;
   localparam int PORT_W    = 2;

   // Management PF0
   localparam logic [PORT_W-1:0] MGMT_PID = 2'd0;
   // Static region
   localparam logic [PORT_W-1:0] SR_PID   = 2'd1;
   // PR region, owns every VF
   localparam logic [PORT_W-1:0] PG_PID   = 2'd2;

   // Port reset length after an FLR
   localparam int FLR_HOLD_CYCLES = 16;
   localparam int HOLD_CNT_W      = 5;

   // ----------------------------------------------------------------------
   // Function id, seen as fields or as a flat table index
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic            vf_active;
      logic [PF_W-1:0] pf;
      logic [VF_W-1:0] vf;
   } t_func_fields;

   typedef union packed {
      t_func_fields      fields;
      logic [FUNC_W-1:0] index;
   } t_func_id;

   // Host FLR request, also reused for ATS request strobes
   typedef struct packed {
      logic     valid;
      t_func_id func;
   } t_flr_req;

   // FLR completion back to the host
   typedef struct packed {
      logic     valid;
      t_func_id func;
   } t_flr_rsp;

   // Decoded request from the routing decoder to the sequencer
   typedef struct packed {
      logic              valid;
      logic [PORT_W-1:0] port;
      t_func_id          func;
   } t_port_sel;

endpackage

// File: logic/flr_route_decoder.sv
`timescale 1ns/1ps

module flr_route_decoder (
   input  logic                 clk_csr,
   input  logic                 i_rst,
   input  flr_pkg::t_flr_req    i_flr_req,
   output flr_pkg::t_port_sel   o_port_sel
);

   // Port picked for the incoming function
   logic [flr_pkg::PORT_W-1:0] port_nxt;

   // ----------------------------------------------------------------------
   // Routing rule
   // ----------------------------------------------------------------------
   always_comb begin
      // VFs all live behind the port gasket
      if (i_flr_req.func.fields.vf_active) begin
         port_nxt = flr_pkg::PG_PID;
      // PF0 itself is the management function
      end else if (i_flr_req.func.fields.pf == '0) begin
         port_nxt = flr_pkg::MGMT_PID;
      // Remaining PFs go to the static region
      end else begin
         port_nxt = flr_pkg::SR_PID;
      end
   end

   // ----------------------------------------------------------------------
   // Output register
   // ----------------------------------------------------------------------
   // Strobe follows the request by one cycle
   always_ff @(posedge clk_csr) begin
      if (i_rst) begin
         o_port_sel.valid <= 1'b0;
      end else begin
         o_port_sel.valid <= i_flr_req.valid;
      end
   end

   // Port and function travel with the strobe
   // Function id is kept so the response can echo it
   always_ff @(posedge clk_csr) begin
      o_port_sel.port <= port_nxt;
      o_port_sel.func <= i_flr_req.func;
   end

endmodule

// File: logic/flr_rsp_sequencer.sv
`timescale 1ns/1ps

module flr_rsp_sequencer (
   input  logic                            clk_csr,
   input  logic                            i_rst,
   input  flr_pkg::t_port_sel              i_port_sel,
   output logic [flr_pkg::NUM_PORTS-1:0]   o_port_rst,
   output flr_pkg::t_flr_rsp               o_flr_rsp
);

   // ----------------------------------------------------------------------
   // State
   // ----------------------------------------------------------------------
   // Two-state FSM, low is idle and high is holding a port in reset
   logic                            hold_q;
   logic [flr_pkg::HOLD_CNT_W-1:0]  hold_cnt;
   logic                            hold_done;
   logic                            rsp_valid_q;

   // Captured at accept time
   logic [flr_pkg::PORT_W-1:0]      port_q;
   flr_pkg::t_func_id               func_q;

   // Last cycle of the hold window
   assign hold_done = (hold_cnt == flr_pkg::HOLD_CNT_W'(flr_pkg::FLR_HOLD_CYCLES - 1));

   // ----------------------------------------------------------------------
   // Hold FSM and counter
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_csr) begin
      if (i_rst) begin
         hold_q      <= 1'b0;
         hold_cnt    <= '0;
         rsp_valid_q <= 1'b0;
      end else begin
         // Response is a single-cycle strobe
         rsp_valid_q <= 1'b0;
         if (!hold_q) begin
            // Only an idle sequencer takes a new select
            // Selects seen while holding are dropped
            if (i_port_sel.valid) begin
               hold_q   <= 1'b1;
               hold_cnt <= '0;
            end
         end else begin
            if (hold_done) begin
               // Release the port and answer the host in the same edge
               hold_q      <= 1'b0;
               rsp_valid_q <= 1'b1;
            end else begin
               hold_cnt <= hold_cnt + 1'b1;
            end
         end
      end
   end

   // Target port and function, loaded only on accept
   always_ff @(posedge clk_csr) begin
      if (!hold_q && i_port_sel.valid) begin
         port_q <= i_port_sel.port;
         func_q <= i_port_sel.func;
      end
   end

   // ----------------------------------------------------------------------
   // Outputs
   // ----------------------------------------------------------------------
   // One-hot reset on the held port while in hold
   always_comb begin
      for (int p = 0; p < flr_pkg::NUM_PORTS; p++) begin
         o_port_rst[p] = hold_q && (port_q == flr_pkg::PORT_W'(p));
      end
   end

   // Response echoes the function that was reset
   assign o_flr_rsp.valid = rsp_valid_q;
   assign o_flr_rsp.func  = func_q;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the FLR testbench with Verilator, then judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timing --timescale 1ns/1ps \
   --top-module tb_afu_flr_top -f sim.f -o sim_afu_flr

# Keep running past assertion errors so the summary is printed
./obj_dir/sim_afu_flr +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -qx "Verification passed" sim.log; then
   exit 0
fi
exit 1

// File: sim.f
logic/flr_pkg.sv
logic/flr_route_decoder.sv
logic/ats_inval_tracker.sv
logic/flr_rsp_sequencer.sv
logic/afu_flr_top.sv
testbench/afu_flr_checker.sv
testbench/tb_afu_flr_top.sv

// File: testbench/afu_flr_checker.sv
`timescale 1ns/1ps

module afu_flr_checker (
   input  logic                            clk_csr,
   input  logic                            i_rst,
   input  flr_pkg::t_flr_req               i_flr_req,
   input  flr_pkg::t_flr_req               i_ats_req,
   input  logic [flr_pkg::NUM_PORTS-1:0]   i_port_rst,
   input  flr_pkg::t_flr_rsp               i_flr_rsp,
   input  logic [flr_pkg::NUM_FUNCS-1:0]   i_ats_inval_en
);

   // Reset is held from FLR age 2 through age 17
   localparam logic [flr_pkg::HOLD_CNT_W-1:0] HOLD_START = flr_pkg::HOLD_CNT_W'(2);
   localparam logic [flr_pkg::HOLD_CNT_W-1:0] HOLD_END   =
      flr_pkg::HOLD_CNT_W'(flr_pkg::FLR_HOLD_CYCLES + 1);

   // Failed assertions so far
   int unsigned fail_cnt = 0;

   // One-hot views of the request strobes
   logic [flr_pkg::NUM_FUNCS-1:0]   ats_mask;
   logic [flr_pkg::NUM_FUNCS-1:0]   flr_mask;
   // Reference invalidation enables
   logic [flr_pkg::NUM_FUNCS-1:0]   exp_inval_en;
   // Reference FLR timeline
   logic [flr_pkg::HOLD_CNT_W-1:0]  age;
   logic                            accepted;
   logic                            rsp_due;
   logic [flr_pkg::PORT_W-1:0]      exp_port;
   logic [flr_pkg::NUM_PORTS-1:0]   exp_port_rst;
   flr_pkg::t_func_id               exp_func;
   flr_pkg::t_func_id               rsp_func;

   // Any VF goes to PG, PF0 to management and other PFs to SR
   function automatic logic [flr_pkg::PORT_W-1:0] route_port(
      input flr_pkg::t_func_id func
   );
      logic [flr_pkg::PORT_W-1:0] port;
      case ({func.fields.vf_active, (func.fields.pf == '0)})
         2'b01:   port = flr_pkg::MGMT_PID;
         2'b00:   port = flr_pkg::SR_PID;
         default: port = flr_pkg::PG_PID;
      endcase
      return port;
   endfunction

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------
   always_comb begin
      ats_mask = '0;
      flr_mask = '0;
      if (i_ats_req.valid)
         ats_mask[i_ats_req.func.index] = 1'b1;
      if (i_flr_req.valid)
         flr_mask[i_flr_req.func.index] = 1'b1;
   end

   // ATS clears and FLR sets with priority while other enables stay
   always_ff @(posedge clk_csr) begin
      if (i_rst) begin
         exp_inval_en <= '1;
      end else begin
         exp_inval_en <= (exp_inval_en & ~ats_mask) | flr_mask;
      end
   end

   // New FLR taken when idle or in the last hold cycle of the previous one
   assign accepted = !i_rst && i_flr_req.valid && (age == '0 || age == HOLD_END);

   always_ff @(posedge clk_csr) begin
      if (i_rst) begin
         age     <= '0;
         rsp_due <= 1'b0;
      end else begin
         // Response one cycle after the hold ends
         rsp_due <= (age == HOLD_END);
         if (accepted) begin
            age <= flr_pkg::HOLD_CNT_W'(1);
         end else if (age == '0 || age == HOLD_END) begin
            age <= '0;
         end else begin
            age <= age + flr_pkg::HOLD_CNT_W'(1);
         end
      end
   end

   always_ff @(posedge clk_csr) begin
      if (accepted) begin
         exp_port <= route_port(i_flr_req.func);
         exp_func <= i_flr_req.func;
      end
      if (age == HOLD_END) begin
         rsp_func <= exp_func;
      end
   end

   always_comb begin
      exp_port_rst = '0;
      if (age >= HOLD_START && age <= HOLD_END) begin
         exp_port_rst[exp_port] = 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // Assertions
   // ----------------------------------------------------------------------
   a_reset_values: assert property (@(posedge clk_csr)
      i_rst |=> (i_port_rst == '0) && !i_flr_rsp.valid && (&i_ats_inval_en))
      else begin
         fail_cnt++;
         $error("ERROR %0t: outputs not at their reset values", $time);
      end

   a_inval_update: assert property (@(posedge clk_csr) disable iff (i_rst)
      i_ats_inval_en == exp_inval_en)
      else begin
         fail_cnt++;
         $error("ERROR %0t: ATS invalidation enables wrong", $time);
      end

   a_port_rst: assert property (@(posedge clk_csr) disable iff (i_rst)
      i_port_rst == exp_port_rst)
      else begin
         fail_cnt++;
         $error("ERROR %0t: port reset %b, expected %b", $time, i_port_rst, exp_port_rst);
      end

   a_flr_rsp: assert property (@(posedge clk_csr) disable iff (i_rst)
      (i_flr_rsp.valid == rsp_due) && (!rsp_due || i_flr_rsp.func == rsp_func))
      else begin
         fail_cnt++;
         $error("ERROR %0t: FLR response wrong or mistimed", $time);
      end

endmodule

// File: testbench/tb_afu_flr_top.sv
`timescale 1ns/1ps

module tb_afu_flr_top;

   // Test lengths in clock cycles
   localparam int RST_CYCLES = 8;
   localparam int NUM_ATS    = 4;
   localparam int NUM_FLRS   = 11;
   localparam int ATS_SLOT   = 3;
   localparam int FLR_SLOT   = 25;
   localparam int RSP_WAIT   = 30;
   localparam int GAP_CYCLES = 3;
   localparam int WATCHDOG_CYCLES =
      RST_CYCLES + 8 + NUM_ATS * ATS_SLOT + NUM_FLRS * FLR_SLOT + 100;

   logic                            clk_csr;
   logic                            i_rst;
   flr_pkg::t_flr_req               i_flr_req;
   flr_pkg::t_flr_req               i_ats_req;
   logic [flr_pkg::NUM_PORTS-1:0]   o_port_rst;
   flr_pkg::t_flr_rsp               o_flr_rsp;
   logic [flr_pkg::NUM_FUNCS-1:0]   o_ats_inval_en;

   integer            seed = 32'hee83_5eb0;
   int unsigned       wait_fail;
   int unsigned       fails_at_start;
   int                test_cnt;
   int                bad_tests;
   flr_pkg::t_func_id ats_funcs [NUM_ATS];

   afu_flr_top DUT (
      .clk_csr        (clk_csr),
      .i_rst          (i_rst),
      .i_flr_req      (i_flr_req),
      .i_ats_req      (i_ats_req),
      .o_port_rst     (o_port_rst),
      .o_flr_rsp      (o_flr_rsp),
      .o_ats_inval_en (o_ats_inval_en)
   );

   bind afu_flr_top afu_flr_checker u_checker (
      .clk_csr        (clk_csr),
      .i_rst          (i_rst),
      .i_flr_req      (i_flr_req),
      .i_ats_req      (i_ats_req),
      .i_port_rst     (o_port_rst),
      .i_flr_rsp      (o_flr_rsp),
      .i_ats_inval_en (o_ats_inval_en)
   );

   initial begin
      clk_csr = 1'b0;
      forever #2 clk_csr = ~clk_csr;
   end

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------
   function automatic flr_pkg::t_func_id random_func();
      flr_pkg::t_func_id func;
      func.index = flr_pkg::FUNC_W'($random(seed));
      return func;
   endfunction

   task automatic send_ats(input flr_pkg::t_func_id func);
      @(posedge clk_csr);
      i_ats_req.valid <= 1'b1;
      i_ats_req.func  <= func;
      @(posedge clk_csr);
      i_ats_req.valid <= 1'b0;
      // Enable drops one cycle after the strobe
      @(posedge clk_csr);
   endtask

   // Optional ATS strobe for the same function in the FLR cycle
   task automatic send_flr(input flr_pkg::t_func_id func, input logic with_ats);
      int waited;
      @(posedge clk_csr);
      i_flr_req.valid <= 1'b1;
      i_flr_req.func  <= func;
      i_ats_req.valid <= with_ats;
      i_ats_req.func  <= func;
      @(posedge clk_csr);
      i_flr_req.valid <= 1'b0;
      i_ats_req.valid <= 1'b0;
      waited = 0;
      do begin
         @(negedge clk_csr);
         waited++;
      end while (!o_flr_rsp.valid && waited < RSP_WAIT);
      if (!o_flr_rsp.valid) begin
         $display("No FLR response within %0d cycles for function %0d", RSP_WAIT, func.index);
         wait_fail++;
      end
      // Keeps consecutive FLRs over 20 cycles apart
      repeat (GAP_CYCLES) @(posedge clk_csr);
   endtask

   task automatic start_test();
      fails_at_start = DUT.u_checker.fail_cnt + wait_fail;
   endtask

   task automatic end_test(input string name);
      int unsigned fails;
      // Let the assertions of the last edge settle
      @(negedge clk_csr);
      fails = DUT.u_checker.fail_cnt + wait_fail - fails_at_start;
      test_cnt++;
      if (fails != 0)
         bad_tests++;
      $display("Test %0d %s: %s, %0d errors", test_cnt, name, (fails == 0) ? "ok" : "bad", fails);
   endtask

   // ----------------------------------------------------------------------
   // Tests
   // ----------------------------------------------------------------------
   initial begin
      flr_pkg::t_func_id func;
      wait_fail = 0;
      test_cnt  = 0;
      bad_tests = 0;
      i_rst     = 1'b1;
      i_flr_req = '0;
      i_ats_req = '0;

      start_test();
      repeat (RST_CYCLES) @(posedge clk_csr);
      i_rst <= 1'b0;
      repeat (2) @(posedge clk_csr);
      end_test("reset values");

      start_test();
      for (int i = 0; i < NUM_ATS; i++) begin
         ats_funcs[i] = random_func();
         send_ats(ats_funcs[i]);
      end
      end_test("ATS clear");

      // Plain re-enable, then FLR against a same-cycle ATS
      start_test();
      send_flr(ats_funcs[0], 1'b0);
      send_flr(ats_funcs[1], 1'b1);
      end_test("FLR set");

      start_test();
      for (int i = 0; i < 4; i++)
         send_flr(random_func(), 1'b0);
      end_test("reset hold and response");

      // PF0, a VF of PF0, then PF1 to PF3
      start_test();
      func = random_func();
      func.fields.vf_active = 1'b0;
      func.fields.pf = '0;
      send_flr(func, 1'b0);
      func = random_func();
      func.fields.vf_active = 1'b1;
      func.fields.pf = '0;
      send_flr(func, 1'b0);
      for (int pf = 1; pf < 4; pf++) begin
         func = random_func();
         func.fields.vf_active = 1'b0;
         func.fields.pf = flr_pkg::PF_W'(pf);
         send_flr(func, 1'b0);
      end
      end_test("routing");

      $display("Tests run %0d, tests with errors %0d, assertion errors %0d, missing responses %0d",
               test_cnt, bad_tests, DUT.u_checker.fail_cnt, wait_fail);
      if (bad_tests == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_csr);
      $display("Run timed out after %0d cycles before the tests finished", WATCHDOG_CYCLES);
      $display("Verification failed");
      $finish;
   end

endmodule
